/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // APB requester side, as driven by the bus master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    // APB completer answer
    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        REG_RAM   = 2'd0,
        REG_IO    = 2'd1,
        REG_FAULT = 2'd2
    } region_t;

    typedef struct packed {
        logic [19:0] page;
        logic [9:0]  index;       // Word index into the RAM
        logic [1:0]  boff;
    } ram_view_t;

    typedef struct packed {
        logic [19:0] page;
        logic [11:0] off;         // Register offset inside the I/O page
    } io_view_t;

    // Same address word, read as RAM location or as I/O register
    typedef union packed {
        ram_view_t ram;
        io_view_t  io;
    } mem_addr_u;

    typedef struct packed {
        logic      valid;
        region_t   region;
        logic      we;
        logic [3:0] strb;
        mem_addr_u addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } mem_rsp_t;

    localparam logic [19:0] MMIO_PAGE     = 20'haaaaa;
    localparam logic [11:0] MMIO_DISP_WEA = 12'h004;
    localparam logic [11:0] MMIO_DISP_DAT = 12'h008;
    localparam logic [11:0] MMIO_LED      = 12'h00c;

endpackage

`default_nettype wire

/* ram_word.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_word #(
    parameter int RAM_WORDS = 1024
) (
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  logic [3:0]  strb,
    input  logic [9:0]  index,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;

    assign idx = index[AW-1:0];  // Upper index bits are zero for any legal RAM address

    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we && strb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[idx];  // Old word on a write, the port drops it anyway
        end
    end

    // The arbiter must never raise a write without selecting the RAM
    assert property (@(posedge clk) we |-> en)
        else $error("ram_word: write enable without en");

endmodule

`default_nettype wire

/* apb_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_port #(
    parameter int RAM_WORDS = 1024,
    parameter bit WRITABLE  = 1'b1
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::apb_req_t apb_req,
    output mem_pkg::apb_rsp_t apb_rsp,
    output mem_pkg::mem_req_t mreq,
    input  mem_pkg::mem_rsp_t mrsp
);
    import mem_pkg::*;

    localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS) * 32'd4;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t    state;
    mem_addr_u addr_u;
    region_t   region;
    logic      access;
    logic      fault;

    assign addr_u = apb_req.paddr;
    assign access = apb_req.psel && apb_req.penable;  // Access phase of APB

    // The I/O page is only reachable from the data port
    always_comb begin
        if (WRITABLE && addr_u.io.page == MMIO_PAGE) begin
            region = REG_IO;
        end else if (apb_req.paddr < RAM_BYTES) begin
            region = REG_RAM;
        end else begin
            region = REG_FAULT;
        end
        if (!WRITABLE && apb_req.pwrite) begin
            region = REG_FAULT;
        end
    end

    assign fault = (region == REG_FAULT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (access && !fault) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mrsp.valid) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;  // One guard cycle while the requester moves on
                end
            endcase
        end
    end

    // Request goes out in the first access cycle and holds until answered
    always_comb begin
        mreq.valid  = (state == ST_IDLE && access && !fault) || state == ST_WAIT;
        mreq.region = region;
        mreq.we     = apb_req.pwrite;
        mreq.strb   = apb_req.pstrb;
        mreq.addr   = addr_u;
        mreq.wdata  = apb_req.pwdata;
    end

    always_comb begin
        apb_rsp.pslverr = state == ST_IDLE && access && fault;  // Error needs no wait state
        apb_rsp.pready  = apb_rsp.pslverr || (state == ST_WAIT && mrsp.valid);
        apb_rsp.prdata  = (state == ST_WAIT && mrsp.valid) ? mrsp.rdata : '0;
    end

    assert property (@(posedge clk) disable iff (rst)
        (access && !apb_rsp.pready) |=> $stable(apb_req.paddr))
        else $error("apb_port: paddr changed during access phase");

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t ireq,
    input  mem_pkg::mem_req_t dreq,
    output mem_pkg::mem_rsp_t irsp,
    output mem_pkg::mem_rsp_t drsp,
    output logic              ram_en,
    output logic              ram_we,
    output logic [3:0]        ram_strb,
    output logic [9:0]        ram_index,
    output logic [31:0]       ram_wdata,
    input  logic [31:0]       ram_rdata,
    output logic              io_sel,
    output logic              io_we,
    output logic [11:0]       io_off,
    output logic [31:0]       io_wdata,
    input  logic [31:0]       io_rdata
);
    import mem_pkg::*;

    logic [1:0]  grant;     // Bit 0 instruction port, bit 1 data port
    logic [1:0]  owner;     // Port whose access is in flight
    logic        busy;
    logic        prio_d;    // Set when the data port wins the next tie
    logic        tgt_io;
    logic [31:0] rdata;
    mem_req_t    sel_req;

    assign busy = |owner;

    always_comb begin
        grant = 2'b00;
        if (!busy) begin
            if (ireq.valid && dreq.valid) begin
                grant = prio_d ? 2'b10 : 2'b01;
            end else if (ireq.valid) begin
                grant = 2'b01;
            end else if (dreq.valid) begin
                grant = 2'b10;
            end
        end
    end

    assign sel_req = grant[1] ? dreq : ireq;

    // Target strobes come straight from the grant so the access starts this cycle
    assign ram_en    = |grant && sel_req.region == REG_RAM;
    assign ram_we    = ram_en && sel_req.we;
    assign ram_strb  = sel_req.strb;
    assign ram_index = sel_req.addr.ram.index;
    assign ram_wdata = sel_req.wdata;

    assign io_sel   = |grant && sel_req.region == REG_IO;
    assign io_we    = io_sel && sel_req.we;
    assign io_off   = sel_req.addr.io.off;
    assign io_wdata = sel_req.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner  <= 2'b00;
            prio_d <= 1'b0;
            tgt_io <= 1'b0;
        end else begin
            owner <= grant;  // Clears itself one cycle after each grant
            if (|grant) begin
                prio_d <= grant[0];
                tgt_io <= io_sel;
            end
        end
    end

    assign rdata = tgt_io ? io_rdata : ram_rdata;

    assign irsp.valid = owner[0];
    assign irsp.rdata = rdata;
    assign drsp.valid = owner[1];
    assign drsp.rdata = rdata;

    // The granted port still holds its request when the answer returns
    assert property (@(posedge clk) disable iff (rst)
        |grant |=> $onehot(owner & {dreq.valid, ireq.valid}))
        else $error("mem_arbiter: granted request dropped before its response");

endmodule

`default_nettype wire

/* mmio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        io_sel,
    input  logic        io_we,
    input  logic [11:0] io_off,
    input  logic [31:0] io_wdata,
    output logic [31:0] io_rdata,
    output logic        disp_wea,
    output logic [31:0] disp_dat,
    output logic [15:0] led
);
    import mem_pkg::*;

    logic [31:0] rd_mux;

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_wea <= 1'b0;
            disp_dat <= '0;
            led      <= '0;
        end else if (io_sel && io_we) begin
            unique case (io_off)
                MMIO_DISP_WEA: begin
                    disp_wea <= io_wdata[0];
                end
                MMIO_DISP_DAT: begin
                    disp_dat <= io_wdata;
                end
                MMIO_LED: begin
                    led <= io_wdata[15:0];
                end
                default: begin
                    // Unmapped offsets drop the write
                end
            endcase
        end
    end

    always_comb begin
        unique case (io_off)
            MMIO_DISP_WEA: begin
                rd_mux = {31'd0, disp_wea};
            end
            MMIO_DISP_DAT: begin
                rd_mux = disp_dat;
            end
            MMIO_LED: begin
                rd_mux = {16'd0, led};
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // Read word lands one cycle after the select, like the RAM
    always_ff @(posedge clk) begin
        if (io_sel) begin
            io_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* mem_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::apb_req_t ibus_req,
    output mem_pkg::apb_rsp_t ibus_rsp,
    input  mem_pkg::apb_req_t dbus_req,
    output mem_pkg::apb_rsp_t dbus_rsp,
    output logic              disp_wea,
    output logic [31:0]       disp_dat,
    output logic [15:0]       led
);
    import mem_pkg::*;

    mem_req_t    ireq;
    mem_req_t    dreq;
    mem_rsp_t    irsp;
    mem_rsp_t    drsp;

    logic        ram_en;
    logic        ram_we;
    logic [3:0]  ram_strb;
    logic [9:0]  ram_index;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;

    logic        io_sel;
    logic        io_we;
    logic [11:0] io_off;
    logic [31:0] io_wdata;
    logic [31:0] io_rdata;

    // Instruction fetch port is read only
    apb_port #(
        .RAM_WORDS(RAM_WORDS),
        .WRITABLE (1'b0)
    ) ibus_port_i (
        .clk    (clk),
        .rst    (rst),
        .apb_req(ibus_req),
        .apb_rsp(ibus_rsp),
        .mreq   (ireq),
        .mrsp   (irsp)
    );

    apb_port #(
        .RAM_WORDS(RAM_WORDS),
        .WRITABLE (1'b1)
    ) dbus_port_i (
        .clk    (clk),
        .rst    (rst),
        .apb_req(dbus_req),
        .apb_rsp(dbus_rsp),
        .mreq   (dreq),
        .mrsp   (drsp)
    );

    mem_arbiter mem_arbiter_i (
        .clk      (clk),
        .rst      (rst),
        .ireq     (ireq),
        .dreq     (dreq),
        .irsp     (irsp),
        .drsp     (drsp),
        .ram_en   (ram_en),
        .ram_we   (ram_we),
        .ram_strb (ram_strb),
        .ram_index(ram_index),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata),
        .io_sel   (io_sel),
        .io_we    (io_we),
        .io_off   (io_off),
        .io_wdata (io_wdata),
        .io_rdata (io_rdata)
    );

    ram_word #(
        .RAM_WORDS(RAM_WORDS)
    ) ram_word_i (
        .clk  (clk),
        .en   (ram_en),
        .we   (ram_we),
        .strb (ram_strb),
        .index(ram_index),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    mmio_regs mmio_regs_i (
        .clk     (clk),
        .rst     (rst),
        .io_sel  (io_sel),
        .io_we   (io_we),
        .io_off  (io_off),
        .io_wdata(io_wdata),
        .io_rdata(io_rdata),
        .disp_wea(disp_wea),
        .disp_dat(disp_dat),
        .led     (led)
    );

endmodule

`default_nettype wire

/* tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// Reference model of the RAM and the I/O registers
logic [31:0] model_ram [RAM_WORDS];
logic        model_wea;
logic [31:0] model_dat;
logic [15:0] model_led;
int          model_last;    // Port that the arbiter granted most recently, 1 is the data port

function automatic void model_reset();
    model_wea  = 1'b0;
    model_dat  = '0;
    model_led  = '0;
    model_last = 1;         // So the instruction port wins the first tie
endfunction

function automatic void model_access(input int port, input logic wr, input logic [31:0] addr,
                                     input logic [31:0] data, input logic [3:0] strb,
                                     output logic [31:0] rd, output logic err);
    int idx;
    rd  = '0;
    err = 1'b0;
    idx = int'(addr >> 2);
    if (port == 1 && addr[31:12] == MMIO_PAGE) begin
        model_last = port;
        if (wr) begin
            case (addr[11:0])
                MMIO_DISP_WEA: model_wea = data[0];
                MMIO_DISP_DAT: model_dat = data;
                MMIO_LED:      model_led = data[15:0];
                default: ;
            endcase
        end else begin
            case (addr[11:0])
                MMIO_DISP_WEA: rd = {31'd0, model_wea};
                MMIO_DISP_DAT: rd = model_dat;
                MMIO_LED:      rd = {16'd0, model_led};
                default:       rd = '0;
            endcase
        end
    end else if (addr < 32'(RAM_WORDS * 4) && !(port == 0 && wr)) begin
        model_last = port;
        if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model_ram[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end else begin
            rd = model_ram[idx];
        end
    end else begin
        err = 1'b1;         // Faults and refused writes touch nothing
    end
endfunction

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic drive_req(input int port, input apb_req_t req);
    if (port == 0) begin
        ibus_req = req;
    end else begin
        dbus_req = req;
    end
endtask

// One APB transfer with setup and access phase, waiting for pready
task automatic apb_xfer(input int port, input logic wr, input logic [31:0] addr,
                        input logic [31:0] data, input logic [3:0] strb,
                        output logic [31:0] rdata, output logic err,
                        output int unsigned done_cyc);
    apb_req_t req;
    apb_rsp_t rsp;
    int       waited;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = wr;
    req.paddr   = addr;
    req.pwdata  = data;
    req.pstrb   = strb;
    drive_req(port, req);
    next_cycle();
    req.penable = 1'b1;
    drive_req(port, req);
    rdata    = '0;
    err      = 1'b0;
    done_cyc = 0;
    rsp      = '0;
    waited   = 0;
    while (!rsp.pready && waited < TIMEOUT) begin
        @(negedge clk);     // Mid-cycle, well after the inputs settled
        rsp = (port == 0) ? ibus_rsp : dbus_rsp;
        if (!rsp.pready) begin
            waited++;
            next_cycle();
        end
    end
    if (rsp.pready) begin
        rdata    = rsp.prdata;
        err      = rsp.pslverr;
        done_cyc = cyc;
    end else begin
        $display("Port %0d got no pready within %0d cycles at time %0t", port, TIMEOUT, $time);
        errors++;
        timed_out = 1'b1;
    end
    next_cycle();
    drive_req(port, '0);
endtask

`endif

/* tb_mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl;
    import mem_pkg::*;

    localparam int RAM_WORDS = 1024;
    localparam int TIMEOUT   = 20;

    typedef struct packed {
        logic [1:0]  port;      // 0 instruction, 1 data, 2 both ports read at once
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        logic        exp_err;
        logic        exp_first; // Data port is expected to finish first in a race
        logic        exp_wea;
        logic [31:0] exp_dat;
        logic [15:0] exp_led;
    } test_row_t;

    logic        clk;
    logic        rst;
    apb_req_t    ibus_req;
    apb_rsp_t    ibus_rsp;
    apb_req_t    dbus_req;
    apb_rsp_t    dbus_rsp;
    logic        disp_wea;
    logic [31:0] disp_dat;
    logic [15:0] led;

    test_row_t   table_q[$];
    int unsigned cyc;
    int          errors;
    logic        row_fail;
    logic        timed_out;

    `include "tb_apb_tasks.svh"

    mem_ctrl_top #(
        .RAM_WORDS(RAM_WORDS)
    ) mem_ctrl_top_i (
        .clk     (clk),
        .rst     (rst),
        .ibus_req(ibus_req),
        .ibus_rsp(ibus_rsp),
        .dbus_req(dbus_req),
        .dbus_rsp(dbus_rsp),
        .disp_wea(disp_wea),
        .disp_dat(disp_dat),
        .led     (led)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            row_fail = 1'b1;
        end
    endtask

    // Expected values are taken from the model in table order
    task automatic add_row(input int port, input logic wr, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb);
        test_row_t row;
        logic      err2;
        logic [31:0] rd2;
        row = '0;
        row.port = 2'(port);
        row.wr   = wr;
        row.addr = addr;
        row.data = data;
        row.strb = strb;
        if (port == 2) begin
            row.exp_first = (model_last == 0);
            model_access(int'(row.exp_first), 1'b0, addr, '0, '0, row.exp_data, row.exp_err);
            model_access(int'(!row.exp_first), 1'b0, addr, '0, '0, rd2, err2);
        end else begin
            model_access(port, wr, addr, data, strb, row.exp_data, row.exp_err);
        end
        row.exp_wea = model_wea;
        row.exp_dat = model_dat;
        row.exp_led = model_led;
        table_q.push_back(row);
    endtask

    initial begin
        test_row_t   row;
        logic [31:0] rd_i;
        logic [31:0] rd_d;
        logic        err_i;
        logic        err_d;
        int unsigned cyc_i;
        int unsigned cyc_d;
        logic [31:0] addr;

        void'($urandom(32'hf7ef_5ec4));
        cyc       = 0;
        errors    = 0;
        timed_out = 1'b0;
        rst       = 1'b1;
        ibus_req  = '0;
        dbus_req  = '0;
        model_reset();

        add_row(1, 1'b1, 32'h0000_0000, 32'h1234_5678, 4'hf);
        add_row(1, 1'b0, 32'h0000_0000, '0, '0);
        add_row(1, 1'b1, 32'h0000_0004, $urandom, 4'hf);
        add_row(1, 1'b1, 32'h0000_0004, $urandom, 4'b0101);
        add_row(1, 1'b0, 32'h0000_0004, '0, '0);
        add_row(1, 1'b1, 32'h0000_0010, $urandom, 4'hf);
        add_row(0, 1'b0, 32'h0000_0010, '0, '0);
        add_row(0, 1'b1, 32'h0000_0010, $urandom, 4'hf);   // Refused, fetch port is read only
        add_row(0, 1'b0, 32'h0000_0010, '0, '0);
        add_row(1, 1'b1, 32'h0000_0008, $urandom, 4'hf);
        add_row(1, 1'b1, 32'haaaa_a004, 32'h0000_0001, 4'hf);
        add_row(1, 1'b1, 32'haaaa_a008, $urandom, 4'hf);
        add_row(1, 1'b1, 32'haaaa_a00c, $urandom, 4'h3);
        add_row(1, 1'b0, 32'haaaa_a004, '0, '0);
        add_row(1, 1'b0, 32'haaaa_a008, '0, '0);
        add_row(1, 1'b0, 32'haaaa_a00c, '0, '0);
        add_row(1, 1'b0, 32'haaaa_a010, '0, '0);
        add_row(1, 1'b0, 32'h0000_0008, '0, '0);             // Word 2 must not see the I/O write
        add_row(0, 1'b0, 32'haaaa_a008, '0, '0);
        add_row(1, 1'b1, 32'h0000_1000, $urandom, 4'hf);     // Past the RAM, index bits alias word 0
        add_row(1, 1'b0, 32'h0000_1000, '0, '0);
        add_row(1, 1'b0, 32'h0000_0000, '0, '0);
        for (int k = 0; k < 4; k++) begin
            addr = 32'h100 + 32'($urandom_range(63, 0)) * 32'd4;
            add_row(1, 1'b1, addr, $urandom, 4'hf);
            add_row(1, 1'b1, addr, $urandom, 4'($urandom_range(15, 1)));
            add_row(k % 2, 1'b0, addr, '0, '0);
        end
        add_row(2, 1'b0, 32'h0000_0004, '0, '0);
        add_row(2, 1'b0, 32'h0000_0010, '0, '0);
        add_row(0, 1'b0, 32'h0000_0000, '0, '0);
        add_row(2, 1'b0, 32'h0000_0008, '0, '0);

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (table_q[n]) begin
            row      = table_q[n];
            row_fail = 1'b0;
            if (row.port == 2'd2) begin
                fork
                    apb_xfer(0, 1'b0, row.addr, '0, '0, rd_i, err_i, cyc_i);
                    apb_xfer(1, 1'b0, row.addr, '0, '0, rd_d, err_d, cyc_d);
                join
                check_value("ibus_rsp.prdata", rd_i, row.exp_data);
                check_value("dbus_rsp.prdata", rd_d, row.exp_data);
                check_value("ibus_rsp.pslverr", {31'd0, err_i}, 32'd0);
                check_value("dbus_rsp.pslverr", {31'd0, err_d}, 32'd0);
                assert (timed_out || (cyc_d < cyc_i) == row.exp_first) else begin
                    $display("Race on address %h finished in the wrong order, data port first is %0b",
                             row.addr, cyc_d < cyc_i);
                    errors++;
                    row_fail = 1'b1;
                end
            end else begin
                apb_xfer(int'(row.port), row.wr, row.addr, row.data, row.strb, rd_d, err_d, cyc_d);
                check_value(row.port == 2'd0 ? "ibus_rsp.pslverr" : "dbus_rsp.pslverr",
                            {31'd0, err_d}, {31'd0, row.exp_err});
                if (!row.wr) begin
                    check_value(row.port == 2'd0 ? "ibus_rsp.prdata" : "dbus_rsp.prdata",
                                rd_d, row.exp_data);
                end
            end
            check_value("disp_wea", {31'd0, disp_wea}, {31'd0, row.exp_wea});
            check_value("disp_dat", disp_dat, row.exp_dat);
            check_value("led", {16'd0, led}, {16'd0, row.exp_led});
            $display("test %0d: port %0d %s addr %h %s", n, row.port, row.wr ? "write" : "read",
                     row.addr, row_fail ? "FAILED" : "ok");
            if (timed_out) begin
                break;
            end
        end

        $display("%0d tests run, %0d errors", table_q.size(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mem_pkg.sv
ram_word.sv
apb_port.sv
mem_arbiter.sv
mmio_regs.sv
mem_ctrl_top.sv
tb_mem_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_mem_ctrl \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
